// ==== source/axis_right_shift.sv ====
// one shift amount holds per packet and bytes shifted out of a beat are dropped, not carried over.
`timescale 1ns/1ns
`include "stream_shift_defines.svh"

module axis_right_shift (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic [`SS_SHIFT_W-1:0]       shift_cfg,
    input  stream_shift_pkg::axis_beat_t s_axis_beat,
    input  logic                         s_axis_valid,
    output logic                         s_axis_ready,
    output stream_shift_pkg::axis_beat_t m_axis_beat,
    output logic                         m_axis_valid,
    input  logic                         m_axis_ready,
    output logic                         pkt_done
);

    import stream_shift_pkg::*;

    // ----------------------------------------
    // pipeline state
    // ----------------------------------------
    // stage one holds the raw beat and its shift amount.
    axis_beat_t             s1_beat;
    logic [`SS_SHIFT_W-1:0] s1_shift;
    logic                   s1_valid;
    // high while the next accepted beat opens a packet.
    logic                   first_beat;
    logic [`SS_SHIFT_W-1:0] shift_sel;
    logic [`SS_DATA_W-1:0]  shifted_data;
    logic                   s_fire;
    logic                   s1_move;
    logic                   s2_open;

    // ----------------------------------------
    // handshakes
    // ----------------------------------------
    // stage two can take a beat when empty or when its beat leaves now.
    assign s2_open = !m_axis_valid || m_axis_ready;
    // stage one moves forward whenever stage two opens.
    assign s1_move = s1_valid && s2_open;
    // input is taken when stage one is empty or is emptied this cycle.
    assign s_axis_ready = !s1_valid || s2_open;
    assign s_fire = s_axis_valid && s_axis_ready;

    // fresh amount from the register on a packet's first beat.
    // later beats reuse the amount latched with the beat before.
    assign shift_sel = first_beat ? shift_cfg : s1_shift;

    // whole-byte right shift with zero fill.
    // an amount of SS_SNUM moves every byte out and leaves zero.
    always_comb begin
        shifted_data = s1_beat.data >> (s1_shift * `SS_BYTE_BITS);
    end

    // ----------------------------------------
    // control registers
    // ----------------------------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            first_beat   <= 1'b1;
            s1_valid     <= 1'b0;
            m_axis_valid <= 1'b0;
        end else begin
            // an accepted last beat means the next beat starts a packet.
            if (s_fire) begin
                first_beat <= s_axis_beat.last;
            end
            // stage one refills or drains only when it may advance.
            if (s_axis_ready) begin
                s1_valid <= s_axis_valid;
            end
            // stage two holds its beat while the sink stalls.
            if (s2_open) begin
                m_axis_valid <= s1_valid;
            end
        end
    end

    // ----------------------------------------
    // payload registers
    // ----------------------------------------
    always_ff @(posedge clock) begin
        // capture the beat with the amount chosen for its packet.
        if (s_fire) begin
            s1_beat  <= s_axis_beat;
            s1_shift <= shift_sel;
        end
        // shifted data and the last flag move on together.
        if (s1_move) begin
            m_axis_beat.data <= shifted_data;
            m_axis_beat.last <= s1_beat.last;
        end
    end

    // one pulse per packet, on the output transfer of its last beat.
    assign pkt_done = m_axis_valid && m_axis_ready && m_axis_beat.last;

endmodule

// ==== source/shift_ctrl_regs.sv ====
// only byte lane 0 of a write reaches the shift register and unmapped addresses answer SLVERR.
`timescale 1ns/1ns
`include "stream_shift_defines.svh"

module shift_ctrl_regs (
    input  logic                       clock,
    input  logic                       rst_n,
    // write address and data.
    input  stream_shift_pkg::axil_aw_t aw,
    input  logic                       awvalid,
    output logic                       awready,
    input  stream_shift_pkg::axil_w_t  w,
    input  logic                       wvalid,
    output logic                       wready,
    // write response.
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    // read address and data.
    input  stream_shift_pkg::axil_ar_t ar,
    input  logic                       arvalid,
    output logic                       arready,
    output stream_shift_pkg::axil_r_t  r,
    output logic                       rvalid,
    input  logic                       rready,
    // stream side.
    input  logic                       pkt_done,
    output logic [`SS_SHIFT_W-1:0]     shift_cfg
);

    import stream_shift_pkg::*;

    // largest legal shift, a full beat.
    localparam logic [`SS_SHIFT_W-1:0] shift_max = `SS_SHIFT_W'(`SS_SNUM);

    axil_r_t                r_next;
    logic [31:0]            pkt_cnt;
    logic                   wr_en;
    logic                   rd_en;
    logic                   wr_shift;
    logic                   wr_pktcnt;
    logic [`SS_SHIFT_W-1:0] wr_shift_val;

    // ----------------------------------------
    // write path
    // ----------------------------------------
    // address and data are taken together, and only with no response pending.
    assign wr_en   = awvalid && wvalid && !bvalid;
    assign awready = wr_en;
    assign wready  = wr_en;

    // address decode.
    assign wr_shift  = (aw.addr == `SS_REG_SHIFT);
    assign wr_pktcnt = (aw.addr == `SS_REG_PKTCNT);

    // low bits of the word, clamped to a full beat.
    assign wr_shift_val = (w.data[`SS_SHIFT_W-1:0] > shift_max) ?
                          shift_max : w.data[`SS_SHIFT_W-1:0];

    // ----------------------------------------
    // read path
    // ----------------------------------------
    // one read in flight at a time.
    assign arready = !rvalid;
    assign rd_en   = arvalid && arready;

    // read mux, unmapped addresses give zero data
    always_comb begin
        r_next.data = '0;
        r_next.resp = `SS_RESP_OKAY;
        case (ar.addr)
            `SS_REG_SHIFT: begin
                r_next.data = {{(32 - `SS_SHIFT_W){1'b0}}, shift_cfg};
            end
            `SS_REG_PKTCNT: begin
                r_next.data = pkt_cnt;
            end
            default: begin
                r_next.resp = `SS_RESP_SLVERR;
            end
        endcase
    end

    // ----------------------------------------
    // registers
    // ----------------------------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            bvalid    <= 1'b0;
            rvalid    <= 1'b0;
            shift_cfg <= '0;
            pkt_cnt   <= '0;
        end else begin
            // response valid one cycle after the handshake, held until taken.
            if (wr_en) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_en) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            // shift bits live in lane 0.
            if (wr_en && wr_shift && w.strb[0]) begin
                shift_cfg <= wr_shift_val;
            end
            // a write to the counter clears it and wins over a count.
            if (wr_en && wr_pktcnt) begin
                pkt_cnt <= '0;
            end else if (pkt_done) begin
                pkt_cnt <= pkt_cnt + 32'd1;
            end
        end
    end

    // response payloads, latched at their handshakes.
    always_ff @(posedge clock) begin
        if (wr_en) begin
            bresp <= (wr_shift || wr_pktcnt) ? `SS_RESP_OKAY : `SS_RESP_SLVERR;
        end
        if (rd_en) begin
            r <= r_next;
        end
    end

endmodule

// ==== source/stream_shift_defines.svh ====
// SS_SHIFT_W must be wide enough to hold SS_SNUM and the register addresses are sized to SS_AXIL_AW.
`ifndef STREAM_SHIFT_DEFINES_SVH
`define STREAM_SHIFT_DEFINES_SVH

// ----------------------------------------
// stream beat geometry
// ----------------------------------------
// bytes carried by one beat.
`define SS_SNUM         8
`define SS_BYTE_BITS    8
`define SS_DATA_W       (`SS_SNUM * `SS_BYTE_BITS)
// shift amounts run from 0 up to SS_SNUM inclusive.
`define SS_SHIFT_W      4

// ----------------------------------------
// control register map
// ----------------------------------------
`define SS_AXIL_AW      4
`define SS_REG_SHIFT    4'h0
`define SS_REG_PKTCNT   4'h4
// axi4-lite response codes.
`define SS_RESP_OKAY    2'b00
`define SS_RESP_SLVERR  2'b10

`endif

// ==== source/stream_shift_pkg.sv ====
// payload widths follow the defines header and tkeep, tid and tuser are not carried on the stream.
`include "stream_shift_defines.svh"

package stream_shift_pkg;

    // ----------------------------------------
    // stream side
    // ----------------------------------------
    // one beat of the byte stream.
    typedef struct packed {
        logic [`SS_DATA_W-1:0] data;
        // marks the final beat of a packet.
        logic                  last;
    } axis_beat_t;

    // ----------------------------------------
    // axi4-lite side
    // ----------------------------------------
    // write address channel.
    typedef struct packed {
        logic [`SS_AXIL_AW-1:0] addr;
        logic [2:0]             prot;
    } axil_aw_t;

    // write data channel, one 32-bit word.
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axil_w_t;

    // read address channel.
    typedef struct packed {
        logic [`SS_AXIL_AW-1:0] addr;
        logic [2:0]             prot;
    } axil_ar_t;

    // read data channel with its response code.
    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axil_r_t;

endpackage

// ==== source/stream_shift_top.sv ====
// the shift amount is latched per packet and software sees it only through the axi4-lite block.
`timescale 1ns/1ns
`include "stream_shift_defines.svh"

module stream_shift_top (
    input  logic                         clock,
    input  logic                         rst_n,
    // byte stream in and out.
    input  stream_shift_pkg::axis_beat_t s_axis_beat,
    input  logic                         s_axis_valid,
    output logic                         s_axis_ready,
    output stream_shift_pkg::axis_beat_t m_axis_beat,
    output logic                         m_axis_valid,
    input  logic                         m_axis_ready,
    // axi4-lite control port.
    input  stream_shift_pkg::axil_aw_t   aw,
    input  logic                         awvalid,
    output logic                         awready,
    input  stream_shift_pkg::axil_w_t    w,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready,
    input  stream_shift_pkg::axil_ar_t   ar,
    input  logic                         arvalid,
    output logic                         arready,
    output stream_shift_pkg::axil_r_t    r,
    output logic                         rvalid,
    input  logic                         rready
);

    // ----------------------------------------
    // links between the two blocks
    // ----------------------------------------
    // current shift register value.
    logic [`SS_SHIFT_W-1:0] shift_cfg;
    // completed packet pulse for the counter.
    logic                   pkt_done;

    shift_ctrl_regs shift_ctrl_regs_inst (
        .clock     (clock),
        .rst_n     (rst_n),
        .aw        (aw),
        .awvalid   (awvalid),
        .awready   (awready),
        .w         (w),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready),
        .pkt_done  (pkt_done),
        .shift_cfg (shift_cfg)
    );

    axis_right_shift axis_right_shift_inst (
        .clock        (clock),
        .rst_n        (rst_n),
        .shift_cfg    (shift_cfg),
        .s_axis_beat  (s_axis_beat),
        .s_axis_valid (s_axis_valid),
        .s_axis_ready (s_axis_ready),
        .m_axis_beat  (m_axis_beat),
        .m_axis_valid (m_axis_valid),
        .m_axis_ready (m_axis_ready),
        .pkt_done     (pkt_done)
    );

endmodule

// ==== stream_shift.f ====
+incdir+source
source/stream_shift_pkg.sv
source/axis_right_shift.sv
source/shift_ctrl_regs.sv
source/stream_shift_top.sv
verif/stream_shift_tb.sv

// ==== verif/stream_shift_tb.sv ====
// seed 36241 is fixed and each wait gives up after wait_limit cycles; tkeep is taken as all ones.
`timescale 1ns/1ns
`include "stream_shift_defines.svh"

module stream_shift_tb;

    import stream_shift_pkg::*;

    localparam int wait_limit = 2000;

    logic clock;
    logic rst_n;
    axis_beat_t s_axis_beat;
    logic s_axis_valid;
    logic s_axis_ready;
    axis_beat_t m_axis_beat;
    logic m_axis_valid;
    logic m_axis_ready;
    axil_aw_t aw;
    logic awvalid;
    logic awready;
    axil_w_t w;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    axil_ar_t ar;
    logic arvalid;
    logic arready;
    axil_r_t r;
    logic rvalid;
    logic rready;

    // reference model state.
    axis_beat_t exp_q[$];
    int model_shift;
    int pkt_shift;
    logic in_first;
    int rx_pkts;
    int errors;
    int timeouts;
    // percent of cycles with the sink stalled.
    int ready_low_pct;

    stream_shift_top stream_shift_top_inst (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // stall the sink at random just after each edge.
    task automatic drive_sink_stalls();
        forever begin
            @(posedge clock);
            #1;
            m_axis_ready = ($urandom_range(99) >= ready_low_pct);
        end
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    // out byte i takes in byte i+sh and is zero past the top byte.
    function automatic logic [`SS_DATA_W-1:0] shift_ref(input logic [`SS_DATA_W-1:0] din,
                                                       input int sh);
        logic [`SS_DATA_W-1:0] dout;
        dout = '0;
        for (int i = 0; i < `SS_SNUM; i++) begin
            if (i + sh < `SS_SNUM)
                dout[i*`SS_BYTE_BITS +: `SS_BYTE_BITS] = din[(i+sh)*`SS_BYTE_BITS +: `SS_BYTE_BITS];
        end
        return dout;
    endfunction

    // low register bits clamped to a full beat.
    function automatic int sat_shift(input logic [31:0] v);
        int lo;
        lo = v[`SS_SHIFT_W-1:0];
        return (lo > `SS_SNUM) ? `SS_SNUM : lo;
    endfunction

    // transfers are seen at the falling edge where both sides are settled.
    always @(negedge clock) begin : stream_monitor
        axis_beat_t want;
        if (rst_n) begin
            if (s_axis_valid && s_axis_ready) begin
                // amount snapshot on a packet's first beat.
                if (in_first)
                    pkt_shift = model_shift;
                want.data = shift_ref(s_axis_beat.data, pkt_shift);
                want.last = s_axis_beat.last;
                exp_q.push_back(want);
                in_first = s_axis_beat.last;
            end
            if (m_axis_valid && m_axis_ready) begin
                if (exp_q.size() == 0) begin
                    $display("output beat at %0t came with no input beat to match it", $time);
                    errors++;
                end else begin
                    want = exp_q.pop_front();
                    if (m_axis_beat.data !== want.data) begin
                        $display("ERR %0t m_axis_beat.data got %h exp %h", $time,
                                 m_axis_beat.data, want.data);
                        errors++;
                    end
                    if (m_axis_beat.last !== want.last) begin
                        $display("ERR %0t m_axis_beat.last got %b exp %b", $time,
                                 m_axis_beat.last, want.last);
                        errors++;
                    end
                    if (m_axis_beat.last)
                        rx_pkts++;
                end
            end
        end
    end

    // ----------------------------------------
    // drivers enter and leave 1 ns after an edge.
    // ----------------------------------------
    task automatic note_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        timeouts++;
    endtask

    task automatic send_beat(input logic [`SS_DATA_W-1:0] data, input logic last);
        int gap;
        int n;
        gap = ($urandom_range(3) == 0) ? $urandom_range(3, 1) : 0;
        repeat (gap) begin
            @(posedge clock);
            #1;
        end
        s_axis_beat.data = data;
        s_axis_beat.last = last;
        s_axis_valid = 1'b1;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (!s_axis_ready && n < wait_limit);
        if (!s_axis_ready)
            note_timeout("s_axis_ready");
        @(posedge clock);
        #1;
        s_axis_valid = 1'b0;
    endtask

    task automatic send_packet(input int beats);
        for (int i = 0; i < beats; i++) begin
            send_beat({$urandom(), $urandom()}, i == beats - 1);
        end
    endtask

    task automatic axil_write(input logic [`SS_AXIL_AW-1:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int n;
        aw.addr = addr;
        w.data = data;
        w.strb = 4'hf;
        awvalid = 1'b1;
        wvalid = 1'b1;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (!(awready && wready) && n < wait_limit);
        if (!(awready && wready))
            note_timeout("awready and wready");
        @(posedge clock);
        #1;
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b1;
        // the register holds the new amount from this edge on.
        if (addr == `SS_REG_SHIFT)
            model_shift = sat_shift(data);
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (!bvalid && n < wait_limit);
        if (!bvalid)
            note_timeout("bvalid");
        resp = bresp;
        @(posedge clock);
        #1;
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [`SS_AXIL_AW-1:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        ar.addr = addr;
        arvalid = 1'b1;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (!arready && n < wait_limit);
        if (!arready)
            note_timeout("arready");
        @(posedge clock);
        #1;
        arvalid = 1'b0;
        rready = 1'b1;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (!rvalid && n < wait_limit);
        if (!rvalid)
            note_timeout("rvalid");
        data = r.data;
        resp = r.resp;
        @(posedge clock);
        #1;
        rready = 1'b0;
    endtask

    // write the shift register and read it back.
    task automatic set_shift(input logic [31:0] v);
        logic [31:0] rdata;
        logic [1:0] resp;
        axil_write(`SS_REG_SHIFT, v, resp);
        if (resp !== `SS_RESP_OKAY) begin
            $display("ERR %0t bresp got %b exp %b", $time, resp, `SS_RESP_OKAY);
            errors++;
        end
        axil_read(`SS_REG_SHIFT, rdata, resp);
        if (rdata !== sat_shift(v)) begin
            $display("ERR %0t r.data got %h exp %h", $time, rdata, sat_shift(v));
            errors++;
        end
        if (resp !== `SS_RESP_OKAY) begin
            $display("ERR %0t r.resp got %b exp %b", $time, resp, `SS_RESP_OKAY);
            errors++;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        do begin
            @(posedge clock);
            #1;
            n++;
        end while (exp_q.size() != 0 && n < wait_limit);
        if (exp_q.size() != 0)
            note_timeout("the output stream to drain");
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        logic [31:0] rdata;
        logic [1:0] resp;
        void'($urandom(36241));
        {rst_n, s_axis_valid, m_axis_ready, awvalid, wvalid, bready, arvalid, rready} = '0;
        s_axis_beat = '0;
        aw = '0;
        w = '0;
        ar = '0;
        {model_shift, pkt_shift, rx_pkts, errors, timeouts} = '0;
        in_first = 1'b1;
        ready_low_pct = 25;
        fork
            drive_sink_stalls();
        join_none
        repeat (16) @(posedge clock);
        #1;
        rst_n = 1'b1;
        @(posedge clock);
        #1;
        // pass-through under back-pressure.
        set_shift(0);
        repeat (12) send_packet($urandom_range(6, 1));
        wait_drain();
        // each legal amount and then values that saturate.
        for (int s = 1; s <= `SS_SNUM; s++) begin
            set_shift(s);
            repeat (3) send_packet($urandom_range(6, 1));
            wait_drain();
        end
        set_shift(12);
        repeat (3) send_packet($urandom_range(6, 1));
        set_shift(15);
        repeat (3) send_packet($urandom_range(6, 1));
        wait_drain();
        // rewrite mid-packet so the tail keeps the old amount.
        set_shift(3);
        send_beat({$urandom(), $urandom()}, 1'b0);
        send_beat({$urandom(), $urandom()}, 1'b0);
        set_shift(5);
        send_beat({$urandom(), $urandom()}, 1'b0);
        send_beat({$urandom(), $urandom()}, 1'b1);
        send_packet(4);
        wait_drain();
        // packet counter against received packets and then cleared.
        axil_read(`SS_REG_PKTCNT, rdata, resp);
        if (rdata !== rx_pkts) begin
            $display("ERR %0t r.data got %0d exp %0d", $time, rdata, rx_pkts);
            errors++;
        end
        axil_write(`SS_REG_PKTCNT, 32'h0, resp);
        if (resp !== `SS_RESP_OKAY) begin
            $display("ERR %0t bresp got %b exp %b", $time, resp, `SS_RESP_OKAY);
            errors++;
        end
        rx_pkts = 0;
        axil_read(`SS_REG_PKTCNT, rdata, resp);
        if (rdata !== 32'd0) begin
            $display("ERR %0t r.data got %0d exp 0", $time, rdata);
            errors++;
        end
        // unmapped address.
        axil_write(4'hc, 32'h5, resp);
        if (resp !== `SS_RESP_SLVERR) begin
            $display("ERR %0t bresp got %b exp %b", $time, resp, `SS_RESP_SLVERR);
            errors++;
        end
        axil_read(4'hc, rdata, resp);
        if (resp !== `SS_RESP_SLVERR || rdata !== 32'd0) begin
            $display("ERR %0t r got %h/%b exp 0/%b", $time, rdata, resp, `SS_RESP_SLVERR);
            errors++;
        end
        $display("errors %0d timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule
